//--- Bender.yml
package:
  name: datamem

sources:
  - source/dmem_map_pkg.sv
  - source/dmem_bus_pkg.sv
  - source/dmem_interconnect.sv
  - source/dmem_ram.sv
  - source/dmem_io.sv
  - source/datamem_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/datamem_tb.sv

//--- datamem_top.f
+incdir+tb
source/dmem_map_pkg.sv
source/dmem_bus_pkg.sv
source/dmem_interconnect.sv
source/dmem_ram.sv
source/dmem_io.sv
source/datamem_top.sv
tb/datamem_tb.sv

//--- source/datamem_top.sv
`timescale 1ns/10ps
`default_nettype none

module datamem_top #(
	parameter int unsigned ram_words = dmem_map_pkg::ram_words_default,
	parameter int unsigned btn_w     = 4,
	parameter int unsigned sw_w      = 3
) (
	input  wire logic                                clk,
	input  wire logic                                nrst,

	// Core load/store port
	input  wire logic                                core_cyc,
	input  wire logic                                core_stb,
	input  wire logic                                core_we,
	input  wire logic [dmem_bus_pkg::adr_w-1:0]      core_adr,
	input  wire logic [dmem_bus_pkg::sel_w-1:0]      core_sel,
	input  wire logic [dmem_bus_pkg::data_w-1:0]     core_dat_w,
	output logic      [dmem_bus_pkg::data_w-1:0]     core_dat_r,
	output logic                                     core_ack,

	// Protocol controller port
	input  wire logic                                con_cyc,
	input  wire logic                                con_stb,
	input  wire logic                                con_we,
	input  wire logic [dmem_bus_pkg::adr_w-1:0]      con_adr,
	input  wire logic [dmem_bus_pkg::sel_w-1:0]      con_sel,
	input  wire logic [dmem_bus_pkg::data_w-1:0]     con_dat_w,
	output logic      [dmem_bus_pkg::data_w-1:0]     con_dat_r,
	output logic                                     con_ack,

	// Board I/O
	input  wire logic [btn_w-1:0]                    btn,
	input  wire logic [sw_w-1:0]                     sw,
	output logic      [3:0]                          led
);

	// Shared target bus
	logic                            ram_stb;
	logic                            io_stb;
	logic                            tgt_we;
	logic [dmem_bus_pkg::adr_w-1:0]  tgt_adr;
	logic [dmem_bus_pkg::sel_w-1:0]  tgt_sel;
	logic [dmem_bus_pkg::data_w-1:0] tgt_dat_w;
	logic [dmem_bus_pkg::data_w-1:0] ram_dat_r;
	logic                            ram_ack;
	logic [dmem_bus_pkg::data_w-1:0] io_dat_r;
	logic                            io_ack;

	// Arbiter and decoder
	dmem_interconnect #(
		.ram_words(ram_words)
	) ic0 (
		.clk, .nrst,
		.core_cyc, .core_stb, .core_we, .core_adr, .core_sel, .core_dat_w,
		.core_dat_r, .core_ack,
		.con_cyc, .con_stb, .con_we, .con_adr, .con_sel, .con_dat_w,
		.con_dat_r, .con_ack,
		.ram_stb, .io_stb, .tgt_we, .tgt_adr, .tgt_sel, .tgt_dat_w,
		.ram_dat_r, .ram_ack, .io_dat_r, .io_ack
	);

	dmem_ram #(
		.ram_words(ram_words)
	) ram0 (
		.clk, .nrst,
		.stb(ram_stb), .we(tgt_we), .adr(tgt_adr), .sel(tgt_sel), .dat_w(tgt_dat_w),
		.dat_r(ram_dat_r), .ack(ram_ack)
	);

	// Buttons, switches, LEDs
	dmem_io #(
		.btn_w(btn_w),
		.sw_w(sw_w)
	) io0 (
		.clk, .nrst,
		.stb(io_stb), .we(tgt_we), .adr(tgt_adr), .sel(tgt_sel), .dat_w(tgt_dat_w),
		.btn, .sw,
		.dat_r(io_dat_r), .ack(io_ack), .led
	);

endmodule

`default_nettype wire

//--- source/dmem_bus_pkg.sv
`default_nettype none

// Shared Wishbone classic bus parameters
package dmem_bus_pkg;

	// Data path width
	localparam int unsigned data_w = 32;

	// One select per byte lane
	localparam int unsigned sel_w = data_w / 8;

	// Word address width
	// 0x000-0x3FF for RAM space, 0x400 and up for I/O
	localparam int unsigned adr_w = 11;

	// Bus masters sharing the memory
	// Core load/store port and protocol controller bridge
	typedef enum logic {
		mst_core,
		mst_con
	} master_t;

endpackage

`default_nettype wire

//--- source/dmem_interconnect.sv
`timescale 1ns/10ps
`default_nettype none

module dmem_interconnect #(
	parameter int unsigned ram_words = dmem_map_pkg::ram_words_default
) (
	input  wire logic                                clk,
	input  wire logic                                nrst,

	// Core master
	input  wire logic                                core_cyc,
	input  wire logic                                core_stb,
	input  wire logic                                core_we,
	input  wire logic [dmem_bus_pkg::adr_w-1:0]      core_adr,
	input  wire logic [dmem_bus_pkg::sel_w-1:0]      core_sel,
	input  wire logic [dmem_bus_pkg::data_w-1:0]     core_dat_w,
	output logic      [dmem_bus_pkg::data_w-1:0]     core_dat_r,
	output logic                                     core_ack,

	// Protocol controller master
	input  wire logic                                con_cyc,
	input  wire logic                                con_stb,
	input  wire logic                                con_we,
	input  wire logic [dmem_bus_pkg::adr_w-1:0]      con_adr,
	input  wire logic [dmem_bus_pkg::sel_w-1:0]      con_sel,
	input  wire logic [dmem_bus_pkg::data_w-1:0]     con_dat_w,
	output logic      [dmem_bus_pkg::data_w-1:0]     con_dat_r,
	output logic                                     con_ack,

	// Shared target side
	output logic                                     ram_stb,
	output logic                                     io_stb,
	output logic                                     tgt_we,
	output logic      [dmem_bus_pkg::adr_w-1:0]      tgt_adr,
	output logic      [dmem_bus_pkg::sel_w-1:0]      tgt_sel,
	output logic      [dmem_bus_pkg::data_w-1:0]     tgt_dat_w,
	input  wire logic [dmem_bus_pkg::data_w-1:0]     ram_dat_r,
	input  wire logic                                ram_ack,
	input  wire logic [dmem_bus_pkg::data_w-1:0]     io_dat_r,
	input  wire logic                                io_ack
);

	logic                              core_req;
	logic                              con_req;
	// Registered grant, valid while the owner holds cyc
	logic                              gnt_valid;
	dmem_bus_pkg::master_t             gnt_owner;
	dmem_bus_pkg::master_t             last_served;
	dmem_bus_pkg::master_t             cur;
	logic                              owner_cyc;
	logic                              locked;
	logic                              busy;
	logic                              gnt_core;
	logic                              gnt_con;
	logic                              cur_stb;
	dmem_map_pkg::target_t             tgt;
	logic                              none_ack;
	logic                              rsp_ack;
	logic [dmem_bus_pkg::data_w-1:0]   rsp_dat;

	assign core_req = core_cyc && core_stb;
	assign con_req  = con_cyc && con_stb;

	// Lock drops as soon as the owner releases cyc
	assign owner_cyc = (gnt_owner == dmem_bus_pkg::mst_core) ? core_cyc : con_cyc;
	assign locked    = gnt_valid && owner_cyc;
	assign busy      = locked || core_req || con_req;

	// Master selection, round robin on contention
	always_comb begin
		if (locked) begin
			cur = gnt_owner;
		end else if (core_req && con_req) begin
			cur = (last_served == dmem_bus_pkg::mst_core) ?
				dmem_bus_pkg::mst_con : dmem_bus_pkg::mst_core;
		end else if (con_req) begin
			cur = dmem_bus_pkg::mst_con;
		end else begin
			cur = dmem_bus_pkg::mst_core;
		end
	end

	assign gnt_core = busy && (cur == dmem_bus_pkg::mst_core);
	assign gnt_con  = busy && (cur == dmem_bus_pkg::mst_con);

	// Forward granted master to the target side
	assign tgt_we    = gnt_con ? con_we    : core_we;
	assign tgt_adr   = gnt_con ? con_adr   : core_adr;
	assign tgt_sel   = gnt_con ? con_sel   : core_sel;
	assign tgt_dat_w = gnt_con ? con_dat_w : core_dat_w;
	assign cur_stb   = (gnt_core && core_stb) || (gnt_con && con_stb);

	// Address decode
	always_comb begin
		if (tgt_adr < ram_words) begin
			tgt = dmem_map_pkg::tgt_ram;
		end else if (tgt_adr == dmem_map_pkg::adr_btn || tgt_adr == dmem_map_pkg::adr_sw ||
				tgt_adr == dmem_map_pkg::adr_led) begin
			tgt = dmem_map_pkg::tgt_io;
		end else begin
			tgt = dmem_map_pkg::tgt_none;
		end
	end

	assign ram_stb = cur_stb && (tgt == dmem_map_pkg::tgt_ram);
	assign io_stb  = cur_stb && (tgt == dmem_map_pkg::tgt_io);

	// Response from the decoded target
	always_comb begin
		case (tgt)
			dmem_map_pkg::tgt_ram: begin
				rsp_ack = ram_ack;
				rsp_dat = ram_dat_r;
			end
			dmem_map_pkg::tgt_io: begin
				rsp_ack = io_ack;
				rsp_dat = io_dat_r;
			end
			default: begin
				rsp_ack = none_ack;
				rsp_dat = '0;
			end
		endcase
	end

	// Only the granted master sees the response
	assign core_ack   = gnt_core && rsp_ack;
	assign con_ack    = gnt_con && rsp_ack;
	assign core_dat_r = gnt_core ? rsp_dat : '0;
	assign con_dat_r  = gnt_con ? rsp_dat : '0;

	always_ff @(posedge clk) begin
		if (!nrst) begin
			gnt_valid   <= 1'b0;
			gnt_owner   <= dmem_bus_pkg::mst_core;
			last_served <= dmem_bus_pkg::mst_con;
			none_ack    <= 1'b0;
		end else begin
			gnt_valid <= busy;
			gnt_owner <= cur;
			// New grant taken, remember who got it
			if (busy && !locked) begin
				last_served <= cur;
			end
			// Unmapped access, single zero-data ack
			none_ack <= cur_stb && (tgt == dmem_map_pkg::tgt_none) && !none_ack;
		end
	end

	// Other master never granted while the owner keeps cyc
	assert property (@(posedge clk) disable iff (!nrst) gnt_core ##1 core_cyc |-> !gnt_con);
	assert property (@(posedge clk) disable iff (!nrst) gnt_con ##1 con_cyc |-> !gnt_core);
	assert property (@(posedge clk) disable iff (!nrst) core_ack |-> core_cyc);
	assert property (@(posedge clk) disable iff (!nrst) con_ack |-> con_cyc);

endmodule

`default_nettype wire

//--- source/dmem_io.sv
`timescale 1ns/10ps
`default_nettype none

module dmem_io #(
	parameter int unsigned btn_w = 4,
	parameter int unsigned sw_w  = 3
) (
	input  wire logic                                clk,
	input  wire logic                                nrst,
	input  wire logic                                stb,
	input  wire logic                                we,
	input  wire logic [dmem_bus_pkg::adr_w-1:0]      adr,
	input  wire logic [dmem_bus_pkg::sel_w-1:0]      sel,
	input  wire logic [dmem_bus_pkg::data_w-1:0]     dat_w,
	input  wire logic [btn_w-1:0]                    btn,
	input  wire logic [sw_w-1:0]                     sw,
	output logic      [dmem_bus_pkg::data_w-1:0]     dat_r,
	output logic                                     ack,
	output logic      [3:0]                          led
);

	// Input capture, zero-extended to bus width
	logic [dmem_bus_pkg::data_w-1:0] btn_q;
	logic [dmem_bus_pkg::data_w-1:0] sw_q;
	logic [dmem_bus_pkg::data_w-1:0] led_q;
	logic                            take;

	assign take = stb && !ack;

	// Board LEDs from the low bits
	assign led = led_q[3:0];

	// Buttons and switches sampled every cycle, no debounce
	always_ff @(posedge clk) begin
		if (!nrst) begin
			btn_q <= '0;
			sw_q  <= '0;
		end else begin
			btn_q <= dmem_bus_pkg::data_w'(btn);
			sw_q  <= dmem_bus_pkg::data_w'(sw);
		end
	end

	// LED register, any mix of byte lanes
	// Writes to btn and sw words fall through here unused
	always_ff @(posedge clk) begin
		if (!nrst) begin
			led_q <= '0;
		end else if (take && we && adr == dmem_map_pkg::adr_led) begin
			for (int i = 0; i < dmem_bus_pkg::sel_w; i++) begin
				if (sel[i]) begin
					led_q[8*i +: 8] <= dat_w[8*i +: 8];
				end
			end
		end
	end

	// Read mux, registered with the ack
	always_ff @(posedge clk) begin
		if (take) begin
			case (adr)
				dmem_map_pkg::adr_btn: dat_r <= btn_q;
				dmem_map_pkg::adr_sw:  dat_r <= sw_q;
				dmem_map_pkg::adr_led: dat_r <= led_q;
				default:               dat_r <= '0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!nrst) begin
			ack <= 1'b0;
		end else begin
			ack <= take;
		end
	end

endmodule

`default_nettype wire

//--- source/dmem_map_pkg.sv
`default_nettype none

// Address map of the data-memory subsystem
// All addresses are word addresses on the shared bus
package dmem_map_pkg;

	// RAM occupies word addresses 0x000 up to ram_words-1
	// 512 words covers 0x000 to 0x1FF
	localparam int unsigned ram_words_default = 512;

	// Memory-mapped I/O words
	// Button capture register, read only
	localparam logic [10:0] adr_btn = 11'h400;

	// Switch capture register, read only
	localparam logic [10:0] adr_sw = 11'h401;

	// LED register, byte writable
	localparam logic [10:0] adr_led = 11'h402;

	// Decoded target of a bus address
	// Anything outside RAM and the three I/O words maps to none
	typedef enum logic [1:0] {
		tgt_none,
		tgt_ram,
		tgt_io
	} target_t;

endpackage

`default_nettype wire

//--- source/dmem_ram.sv
`timescale 1ns/10ps
`default_nettype none

module dmem_ram #(
	parameter int unsigned ram_words = dmem_map_pkg::ram_words_default
) (
	input  wire logic                                clk,
	input  wire logic                                nrst,
	input  wire logic                                stb,
	input  wire logic                                we,
	input  wire logic [dmem_bus_pkg::adr_w-1:0]      adr,
	input  wire logic [dmem_bus_pkg::sel_w-1:0]      sel,
	input  wire logic [dmem_bus_pkg::data_w-1:0]     dat_w,
	output logic      [dmem_bus_pkg::data_w-1:0]     dat_r,
	output logic                                     ack
);

	// Word index bits, depth is a power of two
	localparam int unsigned idx_w = $clog2(ram_words);

	logic [dmem_bus_pkg::data_w-1:0] mem [ram_words];
	logic [idx_w-1:0]                idx;
	// Access taken this cycle, held stb is ignored while acking
	logic                            take;

	assign idx  = adr[idx_w-1:0];
	assign take = stb && !ack;

	// Byte-lane writes, each selected lane independent
	always_ff @(posedge clk) begin
		if (take && we) begin
			for (int i = 0; i < dmem_bus_pkg::sel_w; i++) begin
				if (sel[i]) begin
					mem[idx][8*i +: 8] <= dat_w[8*i +: 8];
				end
			end
		end
	end

	// Registered read, valid alongside ack
	always_ff @(posedge clk) begin
		if (take) begin
			dat_r <= mem[idx];
		end
	end

	// One-cycle acknowledge
	always_ff @(posedge clk) begin
		if (!nrst) begin
			ack <= 1'b0;
		end else begin
			ack <= take;
		end
	end

	// Decode must keep out-of-range words away from the array
	assert property (@(posedge clk) disable iff (!nrst) stb |-> (adr < ram_words));

endmodule

`default_nettype wire

//--- tb/datamem_tb_vectors.svh
`ifndef datamem_tb_vectors_svh
`define datamem_tb_vectors_svh

// Columns: master (0 core, 1 con), we, word address, sel, write data, expected read data
// Expected data only matters on reads, write rows carry zero there
localparam int n_vec = 41;

logic [80:0] vec_tab [n_vec] = '{
	// LED register right after reset
	{1'b0, 1'b0, dmem_map_pkg::adr_led, 4'hf, 32'h0000_0000, 32'h0000_0000},
	// Byte lanes on one RAM word
	{1'b0, 1'b1, 11'h010, 4'hf, 32'h1122_3344, 32'h0000_0000},
	{1'b0, 1'b0, 11'h010, 4'hf, 32'h0000_0000, 32'h1122_3344},
	{1'b0, 1'b1, 11'h010, 4'h1, 32'haabb_ccdd, 32'h0000_0000},
	{1'b0, 1'b0, 11'h010, 4'hf, 32'h0000_0000, 32'h1122_33dd},
	{1'b0, 1'b1, 11'h010, 4'hc, 32'h5566_7788, 32'h0000_0000},
	{1'b0, 1'b0, 11'h010, 4'hf, 32'h0000_0000, 32'h5566_33dd},
	{1'b0, 1'b1, 11'h010, 4'h2, 32'h0000_ee00, 32'h0000_0000},
	{1'b0, 1'b0, 11'h010, 4'hf, 32'h0000_0000, 32'h5566_eedd},
	// Mixed lanes, read back by the other master
	{1'b0, 1'b1, 11'h010, 4'h9, 32'h9900_0077, 32'h0000_0000},
	{1'b1, 1'b0, 11'h010, 4'hf, 32'h0000_0000, 32'h9966_ee77},
	// Top RAM word, middle half written by con
	{1'b0, 1'b1, 11'h1ff, 4'hf, 32'hdead_beef, 32'h0000_0000},
	{1'b1, 1'b1, 11'h1ff, 4'h6, 32'h00c0_ff00, 32'h0000_0000},
	{1'b0, 1'b0, 11'h1ff, 4'hf, 32'h0000_0000, 32'hdec0_ffef},
	{1'b1, 1'b1, 11'h000, 4'hf, 32'h0123_4567, 32'h0000_0000},
	{1'b0, 1'b0, 11'h000, 4'hf, 32'h0000_0000, 32'h0123_4567},
	{1'b0, 1'b1, 11'h0a5, 4'hf, 32'hffff_ffff, 32'h0000_0000},
	{1'b0, 1'b1, 11'h0a5, 4'h5, 32'h0000_0000, 32'h0000_0000},
	{1'b1, 1'b0, 11'h0a5, 4'hf, 32'h0000_0000, 32'hff00_ff00},
	// Alias guard for the unmapped 0x300
	{1'b0, 1'b1, 11'h100, 4'hf, 32'h0bad_cafe, 32'h0000_0000},
	// LED register lanes
	{1'b0, 1'b1, dmem_map_pkg::adr_led, 4'hf, 32'h0000_000a, 32'h0000_0000},
	{1'b0, 1'b0, dmem_map_pkg::adr_led, 4'hf, 32'h0000_0000, 32'h0000_000a},
	{1'b1, 1'b1, dmem_map_pkg::adr_led, 4'h1, 32'h1234_5675, 32'h0000_0000},
	{1'b0, 1'b1, dmem_map_pkg::adr_led, 4'h8, 32'hc300_0000, 32'h0000_0000},
	{1'b1, 1'b0, dmem_map_pkg::adr_led, 4'hf, 32'h0000_0000, 32'hc300_0075},
	{1'b0, 1'b1, dmem_map_pkg::adr_led, 4'h6, 32'hffff_ffff, 32'h0000_0000},
	{1'b0, 1'b0, dmem_map_pkg::adr_led, 4'hf, 32'h0000_0000, 32'hc3ff_ff75},
	// Buttons and switches, writes ignored
	{1'b0, 1'b0, dmem_map_pkg::adr_btn, 4'hf, 32'h0000_0000, 32'h0000_000b},
	{1'b0, 1'b1, dmem_map_pkg::adr_btn, 4'hf, 32'hffff_ffff, 32'h0000_0000},
	{1'b1, 1'b0, dmem_map_pkg::adr_btn, 4'hf, 32'h0000_0000, 32'h0000_000b},
	{1'b0, 1'b0, dmem_map_pkg::adr_sw, 4'hf, 32'h0000_0000, 32'h0000_0005},
	{1'b1, 1'b1, dmem_map_pkg::adr_sw, 4'hf, 32'h1234_5678, 32'h0000_0000},
	{1'b0, 1'b0, dmem_map_pkg::adr_sw, 4'hf, 32'h0000_0000, 32'h0000_0005},
	{1'b1, 1'b0, dmem_map_pkg::adr_led, 4'hf, 32'h0000_0000, 32'hc3ff_ff75},
	// Unmapped words answer with zero
	{1'b0, 1'b0, 11'h300, 4'hf, 32'h0000_0000, 32'h0000_0000},
	{1'b0, 1'b1, 11'h300, 4'hf, 32'hcafe_f00d, 32'h0000_0000},
	{1'b1, 1'b0, 11'h300, 4'hf, 32'h0000_0000, 32'h0000_0000},
	{1'b0, 1'b0, 11'h100, 4'hf, 32'h0000_0000, 32'h0bad_cafe},
	{1'b1, 1'b0, 11'h200, 4'hf, 32'h0000_0000, 32'h0000_0000},
	{1'b0, 1'b0, 11'h7ff, 4'hf, 32'h0000_0000, 32'h0000_0000},
	{1'b1, 1'b0, 11'h010, 4'hf, 32'h0000_0000, 32'h9966_ee77}
};

`endif

//--- tb/datamem_tb.sv
`timescale 1ns/10ps
`default_nettype none

module datamem_tb;

	localparam int unsigned ram_words = dmem_map_pkg::ram_words_default;
	localparam int drv_dly = 2;
	localparam int smp_dly = 10;

	logic clk;
	logic nrst;
	logic core_cyc, core_stb, core_we;
	logic [dmem_bus_pkg::adr_w-1:0] core_adr;
	logic [dmem_bus_pkg::sel_w-1:0] core_sel;
	logic [dmem_bus_pkg::data_w-1:0] core_dat_w;
	logic [dmem_bus_pkg::data_w-1:0] core_dat_r;
	logic core_ack;
	logic con_cyc, con_stb, con_we;
	logic [dmem_bus_pkg::adr_w-1:0] con_adr;
	logic [dmem_bus_pkg::sel_w-1:0] con_sel;
	logic [dmem_bus_pkg::data_w-1:0] con_dat_w;
	logic [dmem_bus_pkg::data_w-1:0] con_dat_r;
	logic con_ack;
	logic [3:0] btn;
	logic [2:0] sw;
	logic [3:0] led;

	`include "datamem_tb_vectors.svh"

	localparam int n_rnd = 12;
	localparam int n_par = 16;
	// Table, three random passes, four concurrent streams
	localparam int n_txn = n_vec + 3 * n_rnd + 4 * n_par;
	localparam int cyc_limit = 10 * n_txn + 100;

	int cycles = 0;
	int data_errs = 0;
	int bus_errs = 0;
	int core_txn = 0;
	int con_txn = 0;
	int core_ack_cnt = 0;
	int con_ack_cnt = 0;
	logic [31:0] lfsr_q = 32'hae04_ffd6;
	// Reference contents of RAM and LED register
	logic [dmem_bus_pkg::data_w-1:0] ram_model [ram_words];
	logic [dmem_bus_pkg::data_w-1:0] led_model;

	datamem_top #(
		.ram_words(ram_words),
		.btn_w(4),
		.sw_w(3)
	) dut0 (
		.clk, .nrst,
		.core_cyc, .core_stb, .core_we, .core_adr, .core_sel, .core_dat_w,
		.core_dat_r, .core_ack,
		.con_cyc, .con_stb, .con_we, .con_adr, .con_sel, .con_dat_w,
		.con_dat_r, .con_ack,
		.btn, .sw, .led
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
		lfsr_q = {lfsr_q[30:0], fb};
		return fb;
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_bit()};
		end
		return v;
	endfunction

	// Selected lanes from new data, the rest kept
	function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [31:0] dat,
			input logic [3:0] sel);
		logic [31:0] res;
		res = old;
		for (int i = 0; i < dmem_bus_pkg::sel_w; i++) begin
			if (sel[i]) begin
				res[8*i +: 8] = dat[8*i +: 8];
			end
		end
		return res;
	endfunction

	task automatic model_write(input logic [10:0] adr, input logic [3:0] sel,
			input logic [31:0] dat);
		if (adr < ram_words) begin
			ram_model[adr] = merge_lanes(ram_model[adr], dat, sel);
		end else if (adr == dmem_map_pkg::adr_led) begin
			led_model = merge_lanes(led_model, dat, sel);
		end
	endtask

	// Expected read data per address map
	function automatic logic [31:0] model_read(input logic [10:0] adr);
		if (adr < ram_words) begin
			return ram_model[adr];
		end else if (adr == dmem_map_pkg::adr_btn) begin
			return {28'h0, btn};
		end else if (adr == dmem_map_pkg::adr_sw) begin
			return {29'h0, sw};
		end else if (adr == dmem_map_pkg::adr_led) begin
			return led_model;
		end
		return 32'h0;
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		assert (act === exp) else begin
			$display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
			data_errs++;
		end
	endtask

	// One classic cycle on the core port
	task automatic core_access(input logic we, input logic [10:0] adr, input logic [3:0] sel,
			input logic [31:0] wdat, output logic [31:0] rdat);
		@(posedge clk);
		#drv_dly;
		core_cyc = 1'b1;
		core_stb = 1'b1;
		core_we = we;
		core_adr = adr;
		core_sel = sel;
		core_dat_w = wdat;
		core_txn++;
		// Held until ack, possibly stalled behind con
		do begin
			@(posedge clk);
			#smp_dly;
		end while (!core_ack && cycles < cyc_limit);
		rdat = core_dat_r;
		assert (core_ack) else begin
			$display("Core access to %h got no ack before the cycle limit", adr);
			bus_errs++;
		end
		@(posedge clk);
		#drv_dly;
		core_cyc = 1'b0;
		core_stb = 1'b0;
		core_we = 1'b0;
	endtask

	// Same cycle on the controller port
	task automatic con_access(input logic we, input logic [10:0] adr, input logic [3:0] sel,
			input logic [31:0] wdat, output logic [31:0] rdat);
		@(posedge clk);
		#drv_dly;
		con_cyc = 1'b1;
		con_stb = 1'b1;
		con_we = we;
		con_adr = adr;
		con_sel = sel;
		con_dat_w = wdat;
		con_txn++;
		do begin
			@(posedge clk);
			#smp_dly;
		end while (!con_ack && cycles < cyc_limit);
		rdat = con_dat_r;
		assert (con_ack) else begin
			$display("Con access to %h got no ack before the cycle limit", adr);
			bus_errs++;
		end
		@(posedge clk);
		#drv_dly;
		con_cyc = 1'b0;
		con_stb = 1'b0;
		con_we = 1'b0;
	endtask

	task automatic run_access(input logic mst, input logic we, input logic [10:0] adr,
			input logic [3:0] sel, input logic [31:0] wdat, output logic [31:0] rdat);
		if (mst) begin
			con_access(we, adr, sel, wdat, rdat);
		end else begin
			core_access(we, adr, sel, wdat, rdat);
		end
	endtask

	// Mid-cycle ack monitor, idle masters must never see ack
	always @(negedge clk) begin
		if (nrst && core_ack) begin
			core_ack_cnt++;
			assert (core_cyc && core_stb) else begin
				$display("Core saw ack at %0t without an open cycle", $time);
				bus_errs++;
			end
		end
		if (nrst && con_ack) begin
			con_ack_cnt++;
			assert (con_cyc && con_stb) else begin
				$display("Con saw ack at %0t without an open cycle", $time);
				bus_errs++;
			end
		end
	end

	// Watchdog
	initial begin
		while (cycles < cyc_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("Run stopped after %0d cycles without finishing", cycles);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		logic [80:0] row;
		logic [31:0] rdat;
		logic [31:0] exp;
		logic [31:0] rnd;
		logic [31:0] core_rd;
		logic [31:0] con_rd;
		logic [10:0] rnd_adr [n_rnd];
		logic [31:0] core_dat [n_par];
		logic [31:0] con_dat [n_par];
		string mst_name;

		nrst = 1'b0;
		core_cyc = 1'b0;
		core_stb = 1'b0;
		core_we = 1'b0;
		core_adr = '0;
		core_sel = '0;
		core_dat_w = '0;
		con_cyc = 1'b0;
		con_stb = 1'b0;
		con_we = 1'b0;
		con_adr = '0;
		con_sel = '0;
		con_dat_w = '0;
		btn = '0;
		sw = '0;
		led_model = '0;
		repeat (2) @(posedge clk);
		#drv_dly;
		nrst = 1'b1;

		// Idle after reset
		@(posedge clk);
		#smp_dly;
		check_value("core_ack", 32'h0, {31'h0, core_ack});
		check_value("con_ack", 32'h0, {31'h0, con_ack});
		check_value("led", 32'h0, {28'h0, led});

		// Inputs settle long before the table reads them
		@(posedge clk);
		#drv_dly;
		btn = 4'hb;
		sw = 3'h5;

		for (int i = 0; i < n_vec; i++) begin
			row = vec_tab[i];
			mst_name = row[80] ? "con_dat_r" : "core_dat_r";
			run_access(row[80], row[79], row[78:68], row[67:64], row[63:32], rdat);
			if (row[79]) begin
				model_write(row[78:68], row[67:64], row[63:32]);
			end else begin
				exp = model_read(row[78:68]);
				assert (exp === row[31:0]) else begin
					$display("Vector %0d expects %h but the model predicts %h", i, row[31:0], exp);
					data_errs++;
				end
				check_value(mst_name, exp, rdat);
			end
			check_value("led", {28'h0, led_model[3:0]}, {28'h0, led});
		end

		// Random words through one master, random lanes through the other
		for (int i = 0; i < n_rnd; i++) begin
			rnd = rand_bits(9);
			rnd_adr[i] = rnd[10:0];
			exp = rand_bits(32);
			run_access(i[0], 1'b1, rnd_adr[i], 4'hf, exp, rdat);
			model_write(rnd_adr[i], 4'hf, exp);
		end
		for (int i = 0; i < n_rnd; i++) begin
			rnd = rand_bits(4);
			exp = rand_bits(32);
			run_access(!i[0], 1'b1, rnd_adr[i], rnd[3:0], exp, rdat);
			model_write(rnd_adr[i], rnd[3:0], exp);
		end
		for (int i = 0; i < n_rnd; i++) begin
			mst_name = i[0] ? "con_dat_r" : "core_dat_r";
			run_access(i[0], 1'b0, rnd_adr[i], 4'hf, 32'h0, rdat);
			check_value(mst_name, model_read(rnd_adr[i]), rdat);
		end

		// Concurrent streams to disjoint words
		for (int i = 0; i < n_par; i++) begin
			core_dat[i] = rand_bits(32);
			con_dat[i] = rand_bits(32);
			model_write(11'h180 + 11'(i), 4'hf, core_dat[i]);
			model_write(11'h190 + 11'(i), 4'hf, con_dat[i]);
		end
		fork
			for (int i = 0; i < n_par; i++) begin
				core_access(1'b1, 11'h180 + 11'(i), 4'hf, core_dat[i], core_rd);
			end
			for (int j = 0; j < n_par; j++) begin
				con_access(1'b1, 11'h190 + 11'(j), 4'hf, con_dat[j], con_rd);
			end
		join
		// Each master reads the other's words
		fork
			for (int i = 0; i < n_par; i++) begin
				core_access(1'b0, 11'h190 + 11'(i), 4'hf, 32'h0, core_rd);
				check_value("core_dat_r", model_read(11'h190 + 11'(i)), core_rd);
			end
			for (int j = 0; j < n_par; j++) begin
				con_access(1'b0, 11'h180 + 11'(j), 4'hf, 32'h0, con_rd);
				check_value("con_dat_r", model_read(11'h180 + 11'(j)), con_rd);
			end
		join

		// Exactly one ack per access
		assert (core_ack_cnt == core_txn && con_ack_cnt == con_txn) else begin
			$display("Ack count off, core %0d acks for %0d accesses, con %0d acks for %0d",
				core_ack_cnt, core_txn, con_ack_cnt, con_txn);
			bus_errs++;
		end
		$display("Errors: data %0d, bus %0d", data_errs, bus_errs);
		if (data_errs == 0 && bus_errs == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
